// File: timer_pkg.sv
package timer_pkg;

    //////////////////////////////////////////////////
    // Time formats
    //////////////////////////////////////////////////

    // One two digit BCD field
    typedef struct packed {
        logic [3:0] tens;
        logic [3:0] units;
    } bcd_pair_t;

    // RTC reading and display format
    typedef struct packed {
        bcd_pair_t hours;
        bcd_pair_t minutes;
        bcd_pair_t seconds;
    } bcd_time_t;

    // Switch setting, plain binary
    typedef struct packed {
        logic [4:0] hours;
        logic [5:0] minutes;
        logic [5:0] seconds;
    } set_time_t;

    typedef logic [16:0] day_secs_t;   // Up to 131071, one day fits

    //////////////////////////////////////////////////
    // Constants
    //////////////////////////////////////////////////

    localparam day_secs_t SECS_PER_MIN  = 17'd60;
    localparam day_secs_t SECS_PER_HOUR = 17'd3600;
    localparam day_secs_t SECS_PER_DAY  = 17'd86400;

    // Field limits, width of a decoded BCD pair
    localparam logic [6:0] MAX_HOURS   = 7'd23;
    localparam logic [6:0] MAX_MIN_SEC = 7'd59;

endpackage

// File: bcd_time_decoder.sv
`timescale 1ns/100ps

module bcd_time_decoder
(
    input  logic                 clk,
    input  logic                 reset,
    input  timer_pkg::bcd_time_t rtc_time,
    input  logic                 rtc_valid,
    output timer_pkg::day_secs_t now_secs,
    output logic                 now_valid
);
    import timer_pkg::*;

    logic [6:0] hours_bin;
    logic [6:0] minutes_bin;
    logic [6:0] seconds_bin;
    logic       time_ok;

    // Both digits decimal
    function automatic logic digits_ok(input bcd_pair_t pair);
        return (pair.tens <= 4'd9) && (pair.units <= 4'd9);
    endfunction

    function automatic logic [6:0] pair_to_bin(input bcd_pair_t pair);
        return 7'(pair.tens) * 7'd10 + 7'(pair.units);
    endfunction

    assign hours_bin   = pair_to_bin(rtc_time.hours);
    assign minutes_bin = pair_to_bin(rtc_time.minutes);
    assign seconds_bin = pair_to_bin(rtc_time.seconds);

    assign time_ok = digits_ok(rtc_time.hours) && (hours_bin <= MAX_HOURS)
                  && digits_ok(rtc_time.minutes) && (minutes_bin <= MAX_MIN_SEC)
                  && digits_ok(rtc_time.seconds) && (seconds_bin <= MAX_MIN_SEC);

    //////////////////////////////////////////////////
    // Seconds of day register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            now_valid <= 1'b0;
        else
            now_valid <= rtc_valid && time_ok;   // Bad readings dropped here
    end

    always_ff @(posedge clk)
    begin
        if (rtc_valid && time_ok)
        begin
            now_secs <= day_secs_t'(hours_bin) * SECS_PER_HOUR
                      + day_secs_t'(minutes_bin) * SECS_PER_MIN
                      + day_secs_t'(seconds_bin);
        end
    end

endmodule

// File: timer_control.sv
`timescale 1ns/100ps

module timer_control
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sw_timer,
    input  logic                 sw_ring,
    input  timer_pkg::set_time_t set_time,
    input  logic                 expired,
    output timer_pkg::day_secs_t duration,
    output logic                 arm,
    output logic                 running,
    output logic                 ring
);
    import timer_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_setting,
        st_running,
        st_ringing
    } state_t;

    state_t     state;
    state_t     state_next;
    logic [4:0] hours_c;
    logic [5:0] minutes_c;
    logic [5:0] seconds_c;
    day_secs_t  setting_secs;
    logic       arm_next;

    // Out of range switch fields clamp to the limit
    assign hours_c   = (7'(set_time.hours) > MAX_HOURS) ? 5'(MAX_HOURS) : set_time.hours;
    assign minutes_c = (7'(set_time.minutes) > MAX_MIN_SEC) ? 6'(MAX_MIN_SEC)
                                                            : set_time.minutes;
    assign seconds_c = (7'(set_time.seconds) > MAX_MIN_SEC) ? 6'(MAX_MIN_SEC)
                                                            : set_time.seconds;

    assign setting_secs = day_secs_t'(hours_c) * SECS_PER_HOUR
                        + day_secs_t'(minutes_c) * SECS_PER_MIN
                        + day_secs_t'(seconds_c);

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        arm_next   = 1'b0;
        case (state)
            st_idle:
                if (sw_timer)
                    state_next = st_setting;
            st_setting:
            begin
                if (!sw_timer)
                begin
                    if (duration == '0)
                        state_next = st_idle;   // Nothing to count
                    else
                    begin
                        state_next = st_running;
                        arm_next   = 1'b1;
                    end
                end
            end
            st_running:
                if (expired)
                    state_next = st_ringing;
            st_ringing:
                if (sw_ring)
                    state_next = st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= st_idle;
            arm      <= 1'b0;
            duration <= '0;
        end
        else
        begin
            state <= state_next;
            arm   <= arm_next;
            if (sw_timer && (state == st_idle || state == st_setting))
                duration <= setting_secs;   // Last value before release wins
        end
    end

    assign running = (state == st_running) || (state == st_ringing);
    assign ring    = (state == st_ringing);

endmodule

// File: countdown_calc.sv
`timescale 1ns/100ps

module countdown_calc
(
    input  logic                 clk,
    input  logic                 reset,
    input  timer_pkg::day_secs_t now_secs,
    input  logic                 now_valid,
    input  timer_pkg::day_secs_t duration,
    input  logic                 arm,
    input  logic                 running,
    output timer_pkg::day_secs_t remaining_secs,
    output logic                 remaining_update,
    output logic                 expired
);
    import timer_pkg::*;

    day_secs_t start_secs;
    day_secs_t elapsed;
    day_secs_t result;
    logic      started;
    logic      fired;       // Expiry already reported
    logic      take;
    logic      first;

    assign take  = now_valid && running;
    assign first = arm || !started;   // Arm restarts the count

    //////////////////////////////////////////////////
    // Elapsed and remaining time
    //////////////////////////////////////////////////

    always_comb
    begin
        elapsed = now_secs - start_secs;
        if (now_secs < start_secs)
            elapsed = elapsed + SECS_PER_DAY;   // Crossed midnight
        if (first)
            result = duration;
        else if (elapsed >= duration)
            result = '0;                        // Saturate
        else
            result = duration - elapsed;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            started          <= 1'b0;
            fired            <= 1'b0;
            remaining_update <= 1'b0;
            expired          <= 1'b0;
        end
        else
        begin
            remaining_update <= take;
            expired          <= take && (result == '0) && (arm || !fired);
            if (arm)
            begin
                started <= 1'b0;
                fired   <= 1'b0;
            end
            if (take)
            begin
                started <= 1'b1;
                if (result == '0)
                    fired <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            remaining_secs <= result;
            if (first)
                start_secs <= now_secs;
        end
    end

endmodule

// File: bcd_time_encoder.sv
`timescale 1ns/100ps

module bcd_time_encoder
(
    input  logic                 clk,
    input  logic                 reset,
    input  timer_pkg::day_secs_t remaining_secs,
    input  logic                 remaining_update,
    output timer_pkg::bcd_time_t remaining
);
    import timer_pkg::*;

    day_secs_t  rest_secs;
    logic [6:0] hours_bin;
    logic [6:0] minutes_bin;
    logic [6:0] seconds_bin;
    bcd_time_t  remaining_next;

    function automatic bcd_pair_t to_bcd_pair(input logic [6:0] value);
        bcd_pair_t pair;
        pair.tens  = 4'(value / 7'd10);
        pair.units = 4'(value % 7'd10);
        return pair;
    endfunction

    //////////////////////////////////////////////////
    // Split into fields
    //////////////////////////////////////////////////

    // Hours stay below 24 since the duration is under a day
    assign hours_bin   = 7'(remaining_secs / SECS_PER_HOUR);
    assign rest_secs   = remaining_secs % SECS_PER_HOUR;
    assign minutes_bin = 7'(rest_secs / SECS_PER_MIN);
    assign seconds_bin = 7'(rest_secs % SECS_PER_MIN);

    always_comb
    begin
        remaining_next.hours   = to_bcd_pair(hours_bin);
        remaining_next.minutes = to_bcd_pair(minutes_bin);
        remaining_next.seconds = to_bcd_pair(seconds_bin);
    end

    //////////////////////////////////////////////////
    // Display register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            remaining <= '0;
        else if (remaining_update)
            remaining <= remaining_next;   // Held until next update
    end

endmodule

// File: countdown_timer.sv
`timescale 1ns/100ps

module countdown_timer
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sw_timer,
    input  logic                 sw_ring,
    input  timer_pkg::set_time_t set_time,
    input  timer_pkg::bcd_time_t rtc_time,
    input  logic                 rtc_valid,
    output timer_pkg::bcd_time_t remaining,
    output logic                 running,
    output logic                 ring
);
    import timer_pkg::*;

    day_secs_t now_secs;
    logic      now_valid;
    day_secs_t duration;
    logic      arm;
    day_secs_t remaining_secs;
    logic      remaining_update;
    logic      expired;

    // RTC side
    bcd_time_decoder i_bcd_time_decoder
    (
        .clk       (clk),
        .reset     (reset),
        .rtc_time  (rtc_time),
        .rtc_valid (rtc_valid),
        .now_secs  (now_secs),
        .now_valid (now_valid)
    );

    // Switch side
    timer_control i_timer_control
    (
        .clk      (clk),
        .reset    (reset),
        .sw_timer (sw_timer),
        .sw_ring  (sw_ring),
        .set_time (set_time),
        .expired  (expired),
        .duration (duration),
        .arm      (arm),
        .running  (running),
        .ring     (ring)
    );

    countdown_calc i_countdown_calc
    (
        .clk              (clk),
        .reset            (reset),
        .now_secs         (now_secs),
        .now_valid        (now_valid),
        .duration         (duration),
        .arm              (arm),
        .running          (running),
        .remaining_secs   (remaining_secs),
        .remaining_update (remaining_update),
        .expired          (expired)
    );

    bcd_time_encoder i_bcd_time_encoder
    (
        .clk              (clk),
        .reset            (reset),
        .remaining_secs   (remaining_secs),
        .remaining_update (remaining_update),
        .remaining        (remaining)
    );

endmodule

// File: countdown_timer_chk.sv
`timescale 1ns/100ps

module countdown_timer_chk
(
    input logic                 clk,
    input logic                 reset,
    input logic                 sw_ring,
    input timer_pkg::bcd_time_t remaining,
    input logic                 running,
    input logic                 ring
);
    import timer_pkg::*;

    // Decimal digits and value within the field limit
    function automatic logic pair_in_range(input bcd_pair_t pair, input logic [6:0] limit);
        return (pair.tens <= 4'd9) && (pair.units <= 4'd9)
            && ((7'(pair.tens) * 7'd10 + 7'(pair.units)) <= limit);
    endfunction

    function automatic logic time_in_range(input bcd_time_t t);
        return pair_in_range(t.hours, MAX_HOURS)
            && pair_in_range(t.minutes, MAX_MIN_SEC)
            && pair_in_range(t.seconds, MAX_MIN_SEC);
    endfunction

    //////////////////////////////////////////////////
    // Output protocol
    //////////////////////////////////////////////////

    property reset_values;
        @(posedge clk) reset |-> (!running && !ring && (remaining == '0));
    endproperty

    property ring_at_zero;
        @(posedge clk) disable iff (reset) $rose(ring) |-> (remaining == '0);
    endproperty

    // Acknowledge ends the whole run
    property ring_acknowledge;
        @(posedge clk) disable iff (reset) (ring && sw_ring) |=> (!ring && !running);
    endproperty

    property display_in_range;
        @(posedge clk) disable iff (reset) running |-> time_in_range(remaining);
    endproperty

    assert property (reset_values)
        else $error("running, ring or remaining not cleared during reset");
    assert property (ring_at_zero)
        else $error("ring rose while the remaining time was not zero");
    assert property (ring_acknowledge)
        else $error("ring or running still high one cycle after sw_ring");
    assert property (display_in_range)
        else $error("remaining is not a valid BCD time of day while running");

endmodule

// File: countdown_timer_tb.sv
`timescale 1ns/100ps

module countdown_timer_tb;
    import timer_pkg::*;

    localparam int WAIT_LIMIT = 50;   // Cycles
    localparam int DAY_SECS   = 86400;

    logic      clk;
    logic      reset;
    logic      sw_timer;
    logic      sw_ring;
    set_time_t set_time;
    bcd_time_t rtc_time;
    logic      rtc_valid;
    bcd_time_t remaining;
    logic      running;
    logic      ring;

    int        duration_secs;
    int        start_secs;
    int        elapsed_secs;
    bcd_time_t expected_shown;   // Display value the model predicts
    bcd_time_t bad_time;

    countdown_timer i_countdown_timer
    (
        .clk       (clk),
        .reset     (reset),
        .sw_timer  (sw_timer),
        .sw_ring   (sw_ring),
        .set_time  (set_time),
        .rtc_time  (rtc_time),
        .rtc_valid (rtc_valid),
        .remaining (remaining),
        .running   (running),
        .ring      (ring)
    );

    bind countdown_timer countdown_timer_chk i_countdown_timer_chk
    (
        .clk       (clk),
        .reset     (reset),
        .sw_ring   (sw_ring),
        .remaining (remaining),
        .running   (running),
        .ring      (ring)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // Time model
    //////////////////////////////////////////////////

    function automatic bcd_pair_t to_bcd_pair(input int value);
        bcd_pair_t pair;
        pair.tens  = 4'(value / 10);
        pair.units = 4'(value % 10);
        return pair;
    endfunction

    function automatic bcd_time_t secs_to_bcd(input int secs);
        bcd_time_t t;
        t.hours   = to_bcd_pair(secs / 3600);
        t.minutes = to_bcd_pair((secs / 60) % 60);
        t.seconds = to_bcd_pair(secs % 60);
        return t;
    endfunction

    // Set duration minus time since start, wrapped at midnight
    function automatic int expected_remaining(input int now_secs);
        int elapsed;
        elapsed = (now_secs - start_secs + DAY_SECS) % DAY_SECS;
        if (elapsed >= duration_secs)
            return 0;
        return duration_secs - elapsed;
    endfunction

    //////////////////////////////////////////////////
    // Checks and stimulus
    //////////////////////////////////////////////////

    task automatic tick();
        @(negedge clk);
    endtask

    task automatic fail_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_display(input string test_name, input bcd_time_t expected);
        assert (remaining == expected)
        else
        begin
            $display("Error %s: expected %h:%h:%h, actual %h:%h:%h", test_name,
                     expected.hours, expected.minutes, expected.seconds,
                     remaining.hours, remaining.minutes, remaining.seconds);
            fail_run();
        end
    endtask

    task automatic check_flag(input string test_name, input string flag_name,
                              input logic expected, input logic actual);
        assert (actual === expected)
        else
        begin
            $display("Error %s: %s expected %b, actual %b", test_name, flag_name,
                     expected, actual);
            fail_run();
        end
    endtask

    task automatic wait_running(input string test_name);
        int cycles;
        cycles = 0;
        while (!running && cycles < WAIT_LIMIT)
        begin
            tick();
            cycles++;
        end
        assert (running)
        else
        begin
            $display("Timeout in %s: running never went high after arming", test_name);
            fail_run();
        end
    endtask

    // Switch setting, then release of sw_timer
    task automatic set_timer(input int h, input int m, input int s);
        sw_timer         = 1'b1;
        set_time.hours   = 5'(h);
        set_time.minutes = 6'(m);
        set_time.seconds = 6'(s);
        repeat (3) tick();
        sw_timer = 1'b0;
        tick();
        duration_secs = h * 3600 + m * 60 + s;
    endtask

    // One strobe, then the 3 cycle pipeline to the display
    task automatic rtc_reading(input bcd_time_t t);
        rtc_time  = t;
        rtc_valid = 1'b1;
        tick();
        rtc_valid = 1'b0;
        repeat (2) tick();
    endtask

    task automatic start_count(input string test_name, input int start);
        start_secs     = start;
        expected_shown = secs_to_bcd(duration_secs);
        rtc_reading(secs_to_bcd(start));
        check_display(test_name, expected_shown);
    endtask

    task automatic reading_at(input string test_name, input int now_secs);
        int left;
        left           = expected_remaining(now_secs);
        expected_shown = secs_to_bcd(left);
        rtc_reading(secs_to_bcd(now_secs));
        check_display(test_name, expected_shown);
        check_flag(test_name, "ring", left == 0, ring);
    endtask

    task automatic acknowledge(input string test_name);
        sw_ring = 1'b1;
        tick();
        sw_ring = 1'b0;
        check_flag(test_name, "ring", 1'b0, ring);
        check_flag(test_name, "running", 1'b0, running);
    endtask

    initial
    begin
        void'($urandom(46));
        clk       = 1'b0;
        reset     = 1'b1;
        sw_timer  = 1'b0;
        sw_ring   = 1'b0;
        set_time  = '0;
        rtc_time  = '0;
        rtc_valid = 1'b0;
        repeat (2) tick();
        reset = 1'b0;
        tick();

        check_flag("reset", "running", 1'b0, running);
        check_flag("reset", "ring", 1'b0, ring);
        check_display("reset", '0);

        // Random duration under an hour
        duration_secs = 1 + $urandom % 3599;
        set_timer(0, duration_secs / 60, duration_secs % 60);
        wait_running("countdown");
        start_count("countdown", $urandom % DAY_SECS);
        elapsed_secs = 0;
        repeat (5)
        begin
            elapsed_secs += $urandom % (duration_secs / 8 + 1);
            reading_at("countdown", (start_secs + elapsed_secs) % DAY_SECS);
        end

        bad_time = secs_to_bcd((start_secs + elapsed_secs) % DAY_SECS);
        bad_time.seconds.units = 4'hA;
        rtc_reading(bad_time);
        check_display("invalid digit", expected_shown);
        bad_time = secs_to_bcd((start_secs + elapsed_secs) % DAY_SECS);
        bad_time.minutes = 8'h60;
        rtc_reading(bad_time);
        check_display("invalid minutes", expected_shown);

        reading_at("expiry", (start_secs + duration_secs + 5) % DAY_SECS);
        reading_at("expiry hold", (start_secs + duration_secs + 9) % DAY_SECS);
        acknowledge("expiry acknowledge");

        // Start 23:59:50, 15 s later across midnight
        set_timer(0, 0, 20);
        wait_running("midnight wrap");
        start_count("midnight wrap", 86390);
        reading_at("midnight wrap", 5);
        check_display("midnight wrap", secs_to_bcd(5));
        reading_at("midnight expiry", 10);
        acknowledge("midnight acknowledge");

        set_timer(0, 0, 0);
        repeat (10)
        begin
            check_flag("zero setting", "running", 1'b0, running);
            tick();
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: list.f
timer_pkg.sv
bcd_time_decoder.sv
timer_control.sv
countdown_calc.sv
bcd_time_encoder.sv
countdown_timer.sv
countdown_timer_chk.sv
countdown_timer_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the countdown timer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module countdown_timer_tb -f list.f -o countdown_timer_sim

out=$(./obj_dir/countdown_timer_sim 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "sim passed"
